//--- dlxBranchCore.f
hw/dlxPkg.sv
hw/programCounter.sv
hw/registerFile.sv
hw/jumpBranch.sv
hw/dlxBranchCore.sv
verif/dlxBranchCore_asserts.sv
verif/tb_dlxBranchCore.sv

//--- hw/dlxBranchCore.sv
`timescale 1ns/1ps
`default_nettype none

module dlxBranchCore
	import dlxPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     fetchEn,     // Fetch enable level
	input  word_t    instruction, // Word at the current pc
	input  logic     regWe,       // Operand preload port
	input  regAddr_t regWaddr,
	input  word_t    regWdata,
	output word_t    pc,
	output logic     takeBranch
);

	// PC path
	word_t pcPlusFour;
	word_t targetPc;

	// Operand read
	word_t rs1;

	// Link write from jal
	logic  linkWe;
	word_t linkData;

	programCounter programCounter_i (
		.clk        (clk),
		.rst        (rst),
		.fetchEn    (fetchEn),
		.takeBranch (takeBranch),
		.targetPc   (targetPc),
		.pc         (pc),
		.pcPlusFour (pcPlusFour)
	);

	// rs field decoded inside the file
	registerFile registerFile_i (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.regWe       (regWe),
		.regWaddr    (regWaddr),
		.regWdata    (regWdata),
		.linkWe      (linkWe),
		.linkData    (linkData),
		.rs1         (rs1)
	);

	// Combinational, same cycle as instruction and rs1
	jumpBranch jumpBranch_i (
		.instruction (instruction),
		.pcPlusFour  (pcPlusFour),
		.rs1         (rs1),
		.fetchEn     (fetchEn),
		.targetPc    (targetPc),
		.takeBranch  (takeBranch),
		.linkWe      (linkWe),
		.linkData    (linkData)
	);

endmodule : dlxBranchCore

`default_nettype wire

//--- hw/dlxPkg.sv
`default_nettype none

package dlxPkg;

	// Instruction, address and register value
	typedef logic [31:0] word_t;

	// Register index, rs field or write address
	typedef logic [4:0] regAddr_t;

	// Control-transfer opcodes, bits 31:26 of the instruction
	typedef enum logic [5:0] {
		OP_J    = 6'h02, // PC+4 + name
		OP_JAL  = 6'h03, // Same target, link to r31
		OP_BEQZ = 6'h04, // Taken when rs1 is zero
		OP_BNEZ = 6'h05, // Taken when rs1 is nonzero
		OP_JR   = 6'h12  // PC from rs1
	} opcode_e;

	// Fetch address after reset
	localparam word_t RESET_PC = 32'h0000_0000;

	// Link register written by jal
	localparam regAddr_t LINK_REG = 5'd31;

endpackage : dlxPkg

`default_nettype wire

//--- hw/jumpBranch.sv
`timescale 1ns/1ps
`default_nettype none

module jumpBranch
	import dlxPkg::*;
(
	input  word_t instruction,
	input  word_t pcPlusFour,  // Base for relative targets
	input  word_t rs1,         // Condition and jr target
	input  logic  fetchEn,
	output word_t targetPc,
	output logic  takeBranch,
	output logic  linkWe,      // Write to r31 this cycle
	output word_t linkData     // Return address for jal
);

	opcode_e opcode;

	// Offset fields
	logic [25:0] name;
	logic [15:0] immi;
	word_t       signExtendedName;
	word_t       signExtendedImmediate;

	// Relative targets
	word_t jumpTarget;
	word_t branchTarget;

	logic rsIsZero;
	logic isJal;

	// Opcode field taken as the enum, unlisted codes fall to default
	assign opcode = opcode_e'(instruction[31:26]);

	assign name = instruction[25:0]; // J-type
	assign immi = instruction[15:0]; // I-type

	// Full-width sign extension of both fields
	assign signExtendedName      = {{6{name[25]}}, name};
	assign signExtendedImmediate = {{16{immi[15]}}, immi};

	assign jumpTarget   = pcPlusFour + signExtendedName;
	assign branchTarget = pcPlusFour + signExtendedImmediate;

	assign rsIsZero = (rs1 == 32'h0);

	// Target and taken flag
	always_comb begin
		targetPc   = pcPlusFour; // Fall-through default
		takeBranch = 1'b0;
		isJal      = 1'b0;
		case (opcode)
			OP_J: begin
				targetPc   = jumpTarget;
				takeBranch = 1'b1;
			end
			OP_JAL: begin
				targetPc   = jumpTarget;
				takeBranch = 1'b1;
				isJal      = 1'b1;
			end
			OP_JR: begin
				targetPc   = rs1; // Absolute from register
				takeBranch = 1'b1;
			end
			OP_BEQZ: begin
				if (rsIsZero) begin
					targetPc   = branchTarget;
					takeBranch = 1'b1;
				end
			end
			OP_BNEZ: begin
				if (!rsIsZero) begin
					targetPc   = branchTarget;
					takeBranch = 1'b1;
				end
			end
			default: begin
				targetPc   = pcPlusFour; // Non-branch opcode
				takeBranch = 1'b0;
			end
		endcase
	end

	// Link only when the jal is actually fetched
	assign linkWe = isJal && fetchEn;

	// Return address skips the delay slot, PC+8
	assign linkData = pcPlusFour + 32'd4;

endmodule : jumpBranch

`default_nettype wire

//--- hw/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter
	import dlxPkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  fetchEn,    // Advance only while high
	input  logic  takeBranch, // Load targetPc instead of PC+4
	input  word_t targetPc,
	output word_t pc,
	output word_t pcPlusFour  // Branch base and fall-through
);

	word_t nextPc;

	// Sequential fetch address
	assign pcPlusFour = pc + 32'd4;

	// Branch target or next word
	always_comb begin
		if (takeBranch) begin
			nextPc = targetPc;
		end else begin
			nextPc = pcPlusFour;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (fetchEn) begin
			pc <= nextPc; // One cycle per fetch
		end
		// Hold otherwise
	end

endmodule : programCounter

`default_nettype wire

//--- hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import dlxPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  word_t    instruction, // rs field selects the read
	input  logic     regWe,       // External write port
	input  regAddr_t regWaddr,
	input  word_t    regWdata,
	input  logic     linkWe,      // Link write from jal
	input  word_t    linkData,
	output word_t    rs1
);

	word_t    regs [32]; // r0 slot never written
	regAddr_t rsAddr;

	// Merged write port
	logic     wrEn;
	regAddr_t wrAddr;
	word_t    wrData;

	assign rsAddr = instruction[25:21]; // rs field

	// Link write wins over a coincident external write
	always_comb begin
		if (linkWe) begin
			wrEn   = 1'b1;
			wrAddr = LINK_REG;
			wrData = linkData;
		end else begin
			wrEn   = regWe;
			wrAddr = regWaddr;
			wrData = regWdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0; // File comes up cleared
			end
		end else if (wrEn && (wrAddr != 5'd0)) begin
			regs[wrAddr] <= wrData; // Writes to r0 dropped
		end
	end

	// Asynchronous read, r0 hardwired to zero
	always_comb begin
		if (rsAddr == 5'd0) begin
			rs1 = '0;
		end else begin
			rs1 = regs[rsAddr];
		end
	end

endmodule : registerFile

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the dlxBranchCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f dlxBranchCore.f --top-module tb_dlxBranchCore \
	-Mdir obj_dir -o simv > "$BUILD_LOG" 2>&1 &&
	./obj_dir/simv +verilator+error+limit+100 > "$SIM_LOG" 2>&1 ||
	{ echo "Build or simulation error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

cat "$SIM_LOG"

grep -q "TEST FAIL" "$SIM_LOG" &&
	{ echo "Simulation failed"; exit 1; } ||
	{ echo "Simulation passed"; exit 0; }

//--- verif/dlxBranchCore_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dlxBranchCore_asserts
	import dlxPkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  fetchEn,
	input word_t pc,
	input word_t instruction,
	input word_t rs1          // Internal read port of the core
);

	int assertFailures = 0; // Assertion failure count

	// Fetch address stays on a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
	else begin
		$error("pc not word aligned");
		assertFailures = assertFailures + 1;
	end

	// No advance while fetch is held
	pcHold: assert property (@(posedge clk) disable iff (rst) !fetchEn |=> $stable(pc))
	else begin
		$error("pc moved with fetch disabled");
		assertFailures = assertFailures + 1;
	end

	// r0 reads as zero
	rsZero: assert property (@(posedge clk) disable iff (rst)
		(instruction[25:21] == 5'd0) |-> (rs1 == 32'd0))
	else begin
		$error("rs1 nonzero for rs field r0");
		assertFailures = assertFailures + 1;
	end

endmodule : dlxBranchCore_asserts

bind dlxBranchCore dlxBranchCore_asserts dlxBranchCore_asserts_i (
	.clk         (clk),
	.rst         (rst),
	.fetchEn     (fetchEn),
	.pc          (pc),
	.instruction (instruction),
	.rs1         (rs1)
);

`default_nettype wire

//--- verif/tb_dlxBranchCore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dlxBranchCore
	import dlxPkg::*;
();

	logic     clk;
	logic     rst;
	logic     fetchEn;
	word_t    instruction;
	logic     regWe;
	regAddr_t regWaddr;
	word_t    regWdata;
	word_t    pc;
	logic     takeBranch;

	// One table row is applied for one cycle and followed by an idle cycle
	typedef struct packed {
		logic        preWe;    // External write in the same cycle
		regAddr_t    preAddr;
		word_t       preData;
		logic [5:0]  opcode;
		regAddr_t    rs;
		logic [25:0] offset;   // Name field or immediate in bits 15:0
		logic        fetch;
		logic        expTaken;
	} step_t;

	step_t steps[$];
	string stepNames[$];

	// Reference state
	word_t modelPc;
	word_t modelRegs [32];

	int errorCount;
	int passCount;
	int failCount;

	dlxBranchCore dlxBranchCore_i (
		.clk         (clk),
		.rst         (rst),
		.fetchEn     (fetchEn),
		.instruction (instruction),
		.regWe       (regWe),
		.regWaddr    (regWaddr),
		.regWdata    (regWdata),
		.pc          (pc),
		.takeBranch  (takeBranch)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	task automatic checkPc(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error: pc = 0x%08h, expected 0x%08h", got, exp);
			errorCount++;
		end
	endtask

	task automatic checkTaken(input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: takeBranch = 0x%0h, expected 0x%0h", got, exp);
			errorCount++;
		end
	endtask

	task automatic logResult(input int index, input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("step %0d (%s) passed", index, name);
		end else begin
			failCount++;
			$display("step %0d (%s) failed", index, name);
		end
	endtask

	task automatic addStep(input logic we, input regAddr_t addr, input word_t data,
			input logic [5:0] op, input regAddr_t rs, input logic [25:0] offset,
			input logic fetch, input logic taken, input string name);
		step_t s;
		s.preWe    = we;
		s.preAddr  = addr;
		s.preData  = data;
		s.opcode   = op;
		s.rs       = rs;
		s.offset   = offset;
		s.fetch    = fetch;
		s.expTaken = taken;
		steps.push_back(s);
		stepNames.push_back(name);
	endtask

	// Word-aligned 26-bit offset with chosen sign
	function automatic logic [25:0] randName(input logic negative);
		logic [25:0] r;
		r      = 26'($urandom);
		r[25]  = negative;
		r[1:0] = 2'b00;
		return r;
	endfunction

	// Word-aligned 16-bit immediate with upper bits unused
	function automatic logic [25:0] randImm(input logic negative);
		logic [15:0] r;
		r      = 16'($urandom);
		r[15]  = negative;
		r[1:0] = 2'b00;
		return {10'd0, r};
	endfunction

	function automatic word_t randWord();
		word_t r;
		r      = $urandom;
		r[1:0] = 2'b00; // Keep jr targets aligned
		r[4]   = 1'b1;  // Never zero
		return r;
	endfunction

	// Two's complement value of the 26-bit name field
	function automatic word_t nameOffset(input logic [25:0] field);
		word_t value;
		value = word_t'(field);
		if (field[25]) begin
			value = value - 32'h0400_0000; // Negative, subtract 2^26
		end
		return value;
	endfunction

	// Two's complement value of the 16-bit immediate
	function automatic word_t immOffset(input logic [15:0] field);
		word_t value;
		value = word_t'(field);
		if (field[15]) begin
			value = value - 32'h0001_0000; // Negative, subtract 2^16
		end
		return value;
	endfunction

	// J-type carries the name field, the rest are I-type with rd zero
	function automatic word_t buildInstr(input step_t s);
		word_t w;
		if (s.opcode == OP_J || s.opcode == OP_JAL) begin
			w = {s.opcode, s.offset};
		end else begin
			w = {s.opcode, s.rs, 5'd0, s.offset[15:0]};
		end
		return w;
	endfunction

	// Next pc from the control-transfer rules
	function automatic word_t expectNextPc(input step_t s);
		word_t plusFour;
		word_t operand;
		word_t target;
		plusFour = modelPc + 32'd4;
		operand  = modelRegs[s.rs];
		target   = plusFour; // Fall-through
		case (s.opcode)
			OP_J, OP_JAL: begin
				target = plusFour + nameOffset(s.offset);
			end
			OP_JR: begin
				target = operand;
			end
			OP_BEQZ: begin
				if (operand == 32'd0) begin
					target = plusFour + immOffset(s.offset[15:0]);
				end
			end
			OP_BNEZ: begin
				if (operand != 32'd0) begin
					target = plusFour + immOffset(s.offset[15:0]);
				end
			end
			default: begin
				target = plusFour;
			end
		endcase
		if (!s.fetch) begin
			target = modelPc; // Held fetch
		end
		return target;
	endfunction

	task automatic updateModel(input step_t s);
		word_t nextPc;
		nextPc = expectNextPc(s);
		if (s.fetch && s.opcode == OP_JAL) begin
			modelRegs[LINK_REG] = modelPc + 32'd8; // Link beats any external write
		end else if (s.preWe && s.preAddr != 5'd0) begin
			modelRegs[s.preAddr] = s.preData;
		end
		modelPc = nextPc;
	endtask

	task automatic buildTable();
		word_t condValue;
		word_t jrValue;
		word_t holdValue;
		word_t overValue;
		word_t zeroValue;
		condValue = randWord();
		jrValue   = randWord();
		holdValue = randWord();
		overValue = randWord();
		zeroValue = randWord();
		// Fall-through
		addStep(1'b0, 5'd0, 32'd0, 6'h00, 5'd0, 26'd0, 1'b1, 1'b0, "nop");
		addStep(1'b0, 5'd0, 32'd0, 6'h08, 5'd3, 26'h10, 1'b1, 1'b0, "addi");
		// j, jal and return through r31
		addStep(1'b0, 5'd0, 32'd0, OP_J, 5'd0, randName(1'b0), 1'b1, 1'b1, "j fwd");
		addStep(1'b0, 5'd0, 32'd0, OP_J, 5'd0, randName(1'b1), 1'b1, 1'b1, "j back");
		addStep(1'b0, 5'd0, 32'd0, OP_JAL, 5'd0, randName(1'b0), 1'b1, 1'b1, "jal fwd");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, LINK_REG, 26'd0, 1'b1, 1'b1, "jr r31 link");
		addStep(1'b0, 5'd0, 32'd0, OP_JAL, 5'd0, randName(1'b1), 1'b1, 1'b1, "jal back");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, LINK_REG, 26'd0, 1'b1, 1'b1, "jr r31 link 2");
		// beqz and bnez on zero and nonzero operands
		addStep(1'b1, 5'd5, 32'd0, 6'h00, 5'd0, 26'd0, 1'b1, 1'b0, "load r5");
		addStep(1'b1, 5'd6, condValue, 6'h00, 5'd0, 26'd0, 1'b1, 1'b0, "load r6");
		addStep(1'b0, 5'd0, 32'd0, OP_BEQZ, 5'd5, randImm(1'b0), 1'b1, 1'b1, "beqz r5");
		addStep(1'b0, 5'd0, 32'd0, OP_BNEZ, 5'd5, randImm(1'b1), 1'b1, 1'b0, "bnez r5");
		addStep(1'b0, 5'd0, 32'd0, OP_BEQZ, 5'd6, randImm(1'b1), 1'b1, 1'b0, "beqz r6");
		addStep(1'b0, 5'd0, 32'd0, OP_BNEZ, 5'd6, randImm(1'b1), 1'b1, 1'b1, "bnez r6 back");
		addStep(1'b0, 5'd0, 32'd0, OP_BNEZ, 5'd6, randImm(1'b0), 1'b1, 1'b1, "bnez r6 fwd");
		addStep(1'b0, 5'd0, 32'd0, OP_BEQZ, 5'd0, randImm(1'b1), 1'b1, 1'b1, "beqz r0");
		// jr
		addStep(1'b1, 5'd7, jrValue, 6'h00, 5'd0, 26'd0, 1'b1, 1'b0, "load r7");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, 5'd7, 26'd0, 1'b1, 1'b1, "jr r7");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, 5'd0, 26'd0, 1'b1, 1'b1, "jr r0");
		// External write still lands while fetch is held
		addStep(1'b1, LINK_REG, holdValue, 6'h00, 5'd0, 26'd0, 1'b0, 1'b0, "load r31 held");
		addStep(1'b0, 5'd0, 32'd0, OP_JAL, 5'd0, randName(1'b0), 1'b0, 1'b1, "jal held");
		addStep(1'b0, 5'd0, 32'd0, OP_J, 5'd0, randName(1'b1), 1'b0, 1'b1, "j held");
		addStep(1'b0, 5'd0, 32'd0, OP_BEQZ, 5'd0, randImm(1'b0), 1'b0, 1'b1, "beqz held");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, LINK_REG, 26'd0, 1'b1, 1'b1, "jr r31 no link");
		// Write priority and r0
		addStep(1'b1, LINK_REG, overValue, OP_JAL, 5'd0, randName(1'b0), 1'b1, 1'b1, "jal wins");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, LINK_REG, 26'd0, 1'b1, 1'b1, "jr r31 linked");
		addStep(1'b1, LINK_REG, overValue, OP_JAL, 5'd0, randName(1'b1), 1'b0, 1'b1, "held jal");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, LINK_REG, 26'd0, 1'b1, 1'b1, "jr r31 external");
		addStep(1'b1, 5'd0, zeroValue, 6'h00, 5'd0, 26'd0, 1'b1, 1'b0, "write r0");
		addStep(1'b0, 5'd0, 32'd0, OP_JR, 5'd0, 26'd0, 1'b1, 1'b1, "jr r0 again");
		addStep(1'b0, 5'd0, 32'd0, OP_BNEZ, 5'd0, randImm(1'b1), 1'b1, 1'b0, "bnez r0");
	endtask

	initial begin
		step_t       s;
		int unsigned seedDummy;
		int          timeout;
		int          errorsBefore;
		seedDummy   = $urandom(28558);
		rst         = 1'b1;
		fetchEn     = 1'b0;
		instruction = '0;
		regWe       = 1'b0;
		regWaddr    = '0;
		regWdata    = '0;
		errorCount  = 0;
		passCount   = 0;
		failCount   = 0;
		modelPc     = RESET_PC;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		buildTable();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		timeout = 0;
		// pc must come out of reset with a known value
		while ($isunknown(pc) && timeout < 8) begin
			@(negedge clk);
			timeout++;
		end
		if ($isunknown(pc)) begin
			$display("Timeout: pc still unknown after reset release");
			$display("TEST FAIL");
			$finish;
		end else begin
			errorsBefore = errorCount;
			checkPc(pc, RESET_PC);
			logResult(0, "reset", errorsBefore);
			for (int k = 0; k < steps.size(); k++) begin
				s            = steps[k];
				errorsBefore = errorCount;
				@(posedge clk);
				regWe       <= s.preWe;
				regWaddr    <= s.preAddr;
				regWdata    <= s.preData;
				instruction <= buildInstr(s);
				fetchEn     <= s.fetch;
				@(negedge clk);
				checkTaken(takeBranch, s.expTaken); // Combinational decode settled
				updateModel(s);
				@(posedge clk);
				regWe       <= 1'b0; // Idle cycle with pc held
				fetchEn     <= 1'b0;
				instruction <= '0;
				@(negedge clk);
				checkPc(pc, modelPc);
				logResult(k + 1, stepNames[k], errorsBefore);
			end
			$display("%0d steps passed, %0d failed, %0d assertion failures", passCount,
				failCount, dlxBranchCore_i.dlxBranchCore_asserts_i.assertFailures);
			if (errorCount == 0 && failCount == 0 &&
					dlxBranchCore_i.dlxBranchCore_asserts_i.assertFailures == 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule : tb_dlxBranchCore

`default_nettype wire
